// ==== list.f ====
source/washer_pkg.sv
source/water_if.sv
source/program_decode.sv
source/water_let.sv
source/cycle_sequencer.sv
source/washer_top.sv
bench/washer_assert.sv
bench/washer_tb.sv

// ==== bench/washer_tb.sv ====
`timescale 1ns/10ps

module washer_tb import washer_pkg::*; ();

    localparam int TICK_DIV = 4;
    // longest program plus pause stays far below this
    localparam int LIMIT = 2000;
    // longer than the heavy wash so a missed freeze would end the phase inside the pause
    localparam int PAUSE_MIN = 13 * TICK_DIV;
    // events that wait_event can wait for
    localparam int WAIT_DONE = 0;
    localparam int WAIT_AGITATE = 1;
    localparam int WAIT_FILLING = 2;
    localparam int WAIT_IDLE = 3;

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    prog_t  prog;
    logic   pause;
    logic   abort;
    phase_t phase;
    level_t level;
    logic   valve_in;
    logic   valve_out;
    logic   motor;
    logic   busy;
    logic   done;

    int          errors = 0;
    int          timeouts = 0;
    // fill count over the whole run and its value at the last start
    int          fills_total = 0;
    int          fills_base = 0;
    logic        valve_in_d = 1'b0;
    // program applied at the last accepted start and its fill goal
    prog_t       prog_run = prog_quick;
    int          level_cap = 7;
    logic [15:0] lfsr = 16'd20491;

    washer_top #(.TICK_DIV(TICK_DIV)) washer_top_i (.*);

    always #2 clk = ~clk;

    // fill goal per program
    function automatic int target_of(prog_t p);
        case (p)
            prog_quick: return 2;
            prog_heavy: return 7;
            default:    return 4;
        endcase
    endfunction

    // rinses per program
    function automatic int rinses_of(prog_t p);
        case (p)
            prog_normal: return 2;
            prog_heavy:  return 3;
            default:     return 1;
        endcase
    endfunction

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    // polls once per clock 1 ns after the edge
    task automatic wait_event(input int ev, input string what);
        int  n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
            case (ev)
                WAIT_DONE:    hit = done;
                WAIT_AGITATE: hit = (phase == ph_wash) || (phase == ph_rinse);
                WAIT_FILLING: hit = (phase == ph_fill) && (level >= 3'd2);
                default:      hit = !busy;
            endcase
        end
        if (!hit) begin
            timeouts++;
            $display("timeout: no %s within %0d cycles", what, LIMIT);
        end
    endtask

    // one-cycle start that remembers what the run should look like
    task automatic apply_start(input prog_t p);
        prog_run   = p;
        level_cap  = target_of(p);
        fills_base = fills_total;
        prog       = p;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // whole program with an optional pause or a second start in agitation
    task automatic run_cycle(input prog_t p, input int pause_len, input logic restart);
        apply_start(p);
        if (pause_len > 0 || restart) begin
            wait_event(WAIT_AGITATE, "wash or rinse phase");
        end
        if (restart) begin
            prog  = (p == prog_heavy) ? prog_quick : prog_heavy;
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        if (pause_len > 0) begin
            pause = 1'b1;
            repeat (pause_len) @(posedge clk);
            #1;
            pause = 1'b0;
        end
        wait_event(WAIT_DONE, "done strobe");
        // one fill for the wash round plus one per rinse
        assert (fills_total - fills_base == 1 + rinses_of(p))
        else report_mismatch($sformatf("%s filled %0d times, expected %0d",
                                       p.name(), fills_total - fills_base, 1 + rinses_of(p)));
        wait_event(WAIT_IDLE, "return to idle after done");
    endtask

    task automatic abort_fill(input prog_t p);
        apply_start(p);
        wait_event(WAIT_FILLING, "partly filled tub");
        abort = 1'b1;
        @(posedge clk);
        #1;
        abort = 1'b0;
        wait_event(WAIT_IDLE, "idle after abort");
    endtask

    // rising edges of the fill valve
    always @(posedge clk) begin
        valve_in_d <= valve_in;
        if (valve_in && !valve_in_d) begin
            fills_total <= fills_total + 1;
        end
    end

    level_cap_chk: assert property (@(posedge clk) disable iff (rst) level <= level_cap)
    else report_mismatch("level above the fill goal of the running program");

    // nothing moves in a timed phase while paused
    pause_hold_chk: assert property (@(posedge clk) disable iff (rst)
        (pause && $past(pause) && ($past(phase) inside {ph_wash, ph_rinse, ph_spin}))
        |-> ($stable(phase) && $stable(level)))
    else report_mismatch("phase or level moved during pause");

    // rinse only has no wash so motor stays off until the second fill
    rinse_only_chk: assert property (@(posedge clk) disable iff (rst)
        (busy && prog_run == prog_rinse_only && fills_total == fills_base + 1) |-> !motor)
    else report_mismatch("motor ran in the first round of rinse only");

    initial begin
        int pv;
        int plen;
        rst   = 1'b1;
        start = 1'b0;
        prog  = prog_quick;
        pause = 1'b0;
        abort = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // each program once
        for (int i = 0; i < 4; i++) begin
            run_cycle(prog_t'(i), 0, 1'b0);
        end
        // random program and random pause length
        repeat (4) begin
            draw_bits(2, pv);
            draw_bits(4, plen);
            run_cycle(prog_t'(pv), plen + PAUSE_MIN, 1'b0);
        end
        run_cycle(prog_normal, 0, 1'b1);
        abort_fill(prog_heavy);
        // machine must recover after abort
        run_cycle(prog_quick, 0, 1'b0);
        repeat (4) @(posedge clk);
        $display("errors: %0d check, %0d assertion, %0d timeout", errors,
                 washer_top_i.washer_assert_i.fail_cnt, timeouts);
        if (errors == 0 && timeouts == 0 && washer_top_i.washer_assert_i.fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/washer_assert.sv ====
`timescale 1ns/10ps

module washer_assert import washer_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   start,
    input logic   abort,
    input phase_t phase,
    input level_t level,
    input logic   valve_in,
    input logic   valve_out,
    input logic   motor,
    input logic   busy,
    input logic   done
);

    // failures seen so far, read by the testbench at the end
    int fail_cnt = 0;

    // first cycle out of reset, everything quiet
    reset_idle_chk: assert property (@(posedge clk) $fell(rst) |->
        (phase == ph_idle && level == '0 && !valve_in && !valve_out && !motor && !busy && !done))
    else begin
        $error("outputs not idle right after reset");
        fail_cnt++;
    end

    // start while idle, busy after accept plus one cycle
    start_busy_chk: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |-> ##[1:2] busy)
    else begin
        $error("busy did not rise within 2 cycles of start");
        fail_cnt++;
    end

    // fill and drain valves are exclusive
    valve_excl_chk: assert property (@(posedge clk) disable iff (rst) !(valve_in && valve_out))
    else begin
        $error("fill and drain valves open together");
        fail_cnt++;
    end

    // level moves one step at a time, flush excepted
    level_step_chk: assert property (@(posedge clk) disable iff (rst) !$past(abort) |->
        (level == $past(level) || level == $past(level) + 1 || level + 1 == $past(level)))
    else begin
        $error("level jumped by more than one step");
        fail_cnt++;
    end

    // tub is empty when the cycle ends
    done_level_chk: assert property (@(posedge clk) disable iff (rst)
        done |-> (level == '0 && phase == ph_done))
    else begin
        $error("done with water still in the tub");
        fail_cnt++;
    end

    // done is a single pulse and busy drops right after
    done_end_chk: assert property (@(posedge clk) disable iff (rst) done |=> (!done && !busy))
    else begin
        $error("done longer than one cycle or busy stayed high");
        fail_cnt++;
    end

    // abort in fill, idle and empty one cycle later
    abort_fill_chk: assert property (@(posedge clk) disable iff (rst)
        (abort && phase == ph_fill) |=> (phase == ph_idle && level == '0 && !valve_in))
    else begin
        $error("abort during fill did not return to an empty idle");
        fail_cnt++;
    end

endmodule

bind washer_top washer_assert washer_assert_i (.*);

// ==== source/washer_top.sv ====
`timescale 1ns/10ps

module washer_top import washer_pkg::*; #(
    parameter int TICK_DIV = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  prog_t  prog,
    input  logic   pause,
    input  logic   abort,
    output phase_t phase,
    output level_t level,
    output logic   valve_in,
    output logic   valve_out,
    output logic   motor,
    output logic   busy,
    output logic   done
);

    // decoder to sequencer
    logic    accept;
    recipe_t recipe;

    // sequencer to fill and drain controller
    water_if water_if_i ();

    program_decode program_decode_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .prog   (prog),
        .busy   (busy),
        .accept (accept),
        .recipe (recipe)
    );

    cycle_sequencer #(
        .TICK_DIV (TICK_DIV)
    ) cycle_sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .recipe    (recipe),
        .pause     (pause),
        .abort     (abort),
        .w         (water_if_i.ctrl),
        .phase     (phase),
        .valve_in  (valve_in),
        .valve_out (valve_out),
        .motor     (motor),
        .busy      (busy),
        .done      (done)
    );

    water_let water_let_i (
        .clk (clk),
        .rst (rst),
        .w   (water_if_i.valve)
    );

    // level comes out of the interface
    assign level = water_if_i.level;

endmodule

// ==== source/cycle_sequencer.sv ====
`timescale 1ns/10ps

module cycle_sequencer import washer_pkg::*; #(
    parameter int TICK_DIV = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    accept,
    input  recipe_t recipe,
    input  logic    pause,
    input  logic    abort,
    water_if.ctrl   w,
    output phase_t  phase,
    output logic    valve_in,
    output logic    valve_out,
    output logic    motor,
    output logic    busy,
    output logic    done
);

    localparam int DIV_W = $clog2(TICK_DIV);

    // prescaler count
    logic [DIV_W-1:0] div_cnt;
    logic             run;
    phase_t           phase_nxt;
    logic             entering;
    // ticks left in wash, rinse or spin
    logic [4:0]       ph_cnt;
    logic             last_tick;
    // rinses still to run, and whether the current round is a rinse
    logic [1:0]       rinse_left;
    logic             in_rinse;

    // prescaler runs only inside a cycle and holds its count on pause
    assign run       = busy & ~pause;
    assign w.tick    = run & (div_cnt == DIV_W'(TICK_DIV - 1));
    assign last_tick = w.tick & (ph_cnt == 5'd1);
    assign entering  = (phase_nxt != phase);

    // fill goal straight from the held recipe
    assign w.target = recipe.target;
    // abort empties the level model on the same edge that forces idle
    assign w.flush  = abort;

    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            div_cnt <= '0;
        end else if (run) begin
            div_cnt <= (div_cnt == DIV_W'(TICK_DIV - 1)) ? '0 : div_cnt + 1'b1;
        end
    end

    // phase transitions
    always_comb begin
        phase_nxt = phase;
        case (phase)
            ph_idle: begin
                if (accept) begin
                    phase_nxt = ph_fill;
                end
            end
            ph_fill: begin
                // zero-tick agitation phases go straight to drain
                if (w.fill_done) begin
                    if (in_rinse) begin
                        phase_nxt = (recipe.rinse_ticks != '0) ? ph_rinse : ph_drain;
                    end else begin
                        phase_nxt = (recipe.wash_ticks != '0) ? ph_wash : ph_drain;
                    end
                end
            end
            ph_wash, ph_rinse: begin
                if (last_tick) begin
                    phase_nxt = ph_drain;
                end
            end
            ph_drain: begin
                // refill for another rinse, or move on to spin
                if (w.drain_done) begin
                    if (rinse_left != '0) begin
                        phase_nxt = ph_fill;
                    end else if (recipe.spin_ticks != '0) begin
                        phase_nxt = ph_spin;
                    end else begin
                        phase_nxt = ph_done;
                    end
                end
            end
            ph_spin: begin
                if (last_tick) begin
                    phase_nxt = ph_done;
                end
            end
            default: phase_nxt = ph_idle;
        endcase
        // abort wins over everything
        if (abort) begin
            phase_nxt = ph_idle;
        end
    end

    // phase register, go strobes and status outputs all from phase_nxt
    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= ph_idle;
            w.fill_go  <= 1'b0;
            w.drain_go <= 1'b0;
            valve_in   <= 1'b0;
            valve_out  <= 1'b0;
            motor      <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            phase      <= phase_nxt;
            w.fill_go  <= entering && (phase_nxt == ph_fill);
            w.drain_go <= entering && (phase_nxt == ph_drain);
            valve_in   <= (phase_nxt == ph_fill);
            valve_out  <= (phase_nxt == ph_drain) || (phase_nxt == ph_spin);
            motor      <= (phase_nxt == ph_wash) || (phase_nxt == ph_rinse)
                          || (phase_nxt == ph_spin);
            busy       <= (phase_nxt != ph_idle);
            done       <= (phase_nxt == ph_done);
        end
    end

    // rinse bookkeeping, first round washes, later rounds rinse
    always_ff @(posedge clk) begin
        if (rst) begin
            rinse_left <= '0;
            in_rinse   <= 1'b0;
        end else if (phase == ph_idle && phase_nxt == ph_fill) begin
            rinse_left <= recipe.rinse_count;
            in_rinse   <= 1'b0;
        end else if (phase == ph_drain && phase_nxt == ph_fill) begin
            rinse_left <= rinse_left - 1'b1;
            in_rinse   <= 1'b1;
        end
    end

    // tick counter, loaded on entry to a timed phase
    always_ff @(posedge clk) begin
        if (rst) begin
            ph_cnt <= '0;
        end else if (entering) begin
            case (phase_nxt)
                ph_wash:  ph_cnt <= recipe.wash_ticks;
                ph_rinse: ph_cnt <= {2'b00, recipe.rinse_ticks};
                ph_spin:  ph_cnt <= {2'b00, recipe.spin_ticks};
                default:  ph_cnt <= '0;
            endcase
        end else if (w.tick && ph_cnt != '0) begin
            ph_cnt <= ph_cnt - 1'b1;
        end
    end

endmodule

// ==== source/water_let.sv ====
`timescale 1ns/10ps

module water_let (
    input logic clk,
    input logic rst,
    water_if.valve w
);

    // current mode of the valve pair
    logic filling;
    logic draining;
    // mode in effect this cycle, a go strobe takes over at once
    logic fill_act;
    logic drain_act;

    // a go strobe acts in its own cycle so no tick is lost at phase entry
    assign fill_act  = w.fill_go | (filling & ~w.drain_go);
    assign drain_act = w.drain_go | (draining & ~w.fill_go);

    always_ff @(posedge clk) begin
        if (rst || w.flush) begin
            // flush empties the tub and drops any pending request
            filling      <= 1'b0;
            draining     <= 1'b0;
            w.level      <= '0;
            w.fill_done  <= 1'b0;
            w.drain_done <= 1'b0;
        end else begin
            // done strobes last one cycle
            w.fill_done  <= 1'b0;
            w.drain_done <= 1'b0;
            filling      <= fill_act;
            draining     <= drain_act;

            if (fill_act) begin
                // goal reached, report and leave fill mode
                if (w.level >= w.target) begin
                    w.fill_done <= 1'b1;
                    filling     <= 1'b0;
                end else if (w.tick) begin
                    w.level <= w.level + 1'b1;
                end
            end else if (drain_act) begin
                // empty, report and leave drain mode
                if (w.level == '0) begin
                    w.drain_done <= 1'b1;
                    draining     <= 1'b0;
                end else if (w.tick) begin
                    w.level <= w.level - 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/program_decode.sv ====
`timescale 1ns/10ps

module program_decode import washer_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  prog_t   prog,
    input  logic    busy,
    output logic    accept,
    output recipe_t recipe
);

    logic take;

    // start only counts while no cycle runs
    // accept itself blocks a second start one cycle later,
    // since busy only rises after the sequencer has seen accept
    assign take = start & ~busy & ~accept;

    // accept strobe, one cycle after the qualified start
    always_ff @(posedge clk) begin
        if (rst) begin
            accept <= 1'b0;
        end else begin
            accept <= take;
        end
    end

    // recipe is captured on the same edge that raises accept,
    // so the sequencer sees a valid recipe together with accept
    // prog may change freely afterwards, the held copy stays
    always_ff @(posedge clk) begin
        if (take) begin
            recipe <= recipe_of(prog);
        end
    end

endmodule

// ==== source/water_if.sv ====
`timescale 1ns/10ps

interface water_if import washer_pkg::*; ();

    // time base from the sequencer prescaler
    logic   tick;
    // one-cycle requests to start filling or draining
    logic   fill_go;
    logic   drain_go;
    // fill goal, held for the whole cycle
    level_t target;
    // modelled water level
    level_t level;
    // one-cycle completion strobes
    logic   fill_done;
    logic   drain_done;
    // empties the tub at once, used on abort
    logic   flush;

    // sequencer side
    modport ctrl (
        output tick, fill_go, drain_go, target, flush,
        input  level, fill_done, drain_done
    );

    // fill and drain controller side
    modport valve (
        input  tick, fill_go, drain_go, target, flush,
        output level, fill_done, drain_done
    );

endinterface

// ==== source/washer_pkg.sv ====
package washer_pkg;

    // water level is a small count, one step per tick
    localparam int level_w = 3;

    typedef logic [level_w-1:0] level_t;

    // operator program selection
    typedef enum logic [1:0] {
        prog_quick,
        prog_normal,
        prog_heavy,
        prog_rinse_only
    } prog_t;

    // cycle phases, idle must stay zero
    typedef enum logic [2:0] {
        ph_idle,
        ph_fill,
        ph_wash,
        ph_drain,
        ph_rinse,
        ph_spin,
        ph_done
    } phase_t;

    // one program's timing, 16 bits packed
    typedef struct packed {
        level_t      target;
        logic [4:0]  wash_ticks;
        logic [1:0]  rinse_count;
        logic [2:0]  rinse_ticks;
        logic [2:0]  spin_ticks;
    } recipe_t;

    // fixed program table
    function automatic recipe_t recipe_of(prog_t p);
        recipe_t r;
        case (p)
            prog_quick:  r = '{target: 3'd2, wash_ticks: 5'd4, rinse_count: 2'd1,
                               rinse_ticks: 3'd2, spin_ticks: 3'd2};
            prog_normal: r = '{target: 3'd4, wash_ticks: 5'd8, rinse_count: 2'd2,
                               rinse_ticks: 3'd2, spin_ticks: 3'd4};
            prog_heavy:  r = '{target: 3'd7, wash_ticks: 5'd12, rinse_count: 2'd3,
                               rinse_ticks: 3'd3, spin_ticks: 3'd6};
            // rinse only, wash phase is skipped
            default:     r = '{target: 3'd4, wash_ticks: 5'd0, rinse_count: 2'd1,
                               rinse_ticks: 3'd2, spin_ticks: 3'd2};
        endcase
        return r;
    endfunction

endpackage
